// ==== verilog/rv_pkg.sv ====
// shared types and constants for the rv64i core; import into each rtl module.
package rv_pkg;

  localparam int xlen = 64; // datapath width.

  localparam logic [6:0] op_imm    = 7'b0010011; // addi and friends.
  localparam logic [6:0] op_op     = 7'b0110011; // add, sub.
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011; // ebreak lives here.

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t; // register-register.

  typedef struct packed {
    logic [11:0] imm_11_0; // also funct12 / shamt.
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_t; // stores.

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef struct packed {
    logic        imm_20;
    logic [9:0]  imm_10_1;
    logic        imm_11;
    logic [7:0]  imm_19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_j_t; // scrambled jump offset.

  // one fetched word, viewed per format.
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_u_t u;
    rv_j_t j;
  } rv_inst_u;

  typedef struct packed {
    logic add;
    logic sub;
    logic lt;   // signed set-less-than.
    logic ltu;  // unsigned.
    logic and_;
    logic or_;
    logic xor_;
    logic sll;
  } alu_op_t; // one-hot.

  typedef struct packed {
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;       // sign-extended.
    logic            need_imm;  // operand b from imm.
    alu_op_t         alu_op;
    logic            is_auipc;
    logic            is_jal;
    logic            is_jalr;
    logic            is_load;
    logic            is_ebreak;
    logic            reg_wen;
    logic            mem_wen;
    logic [7:0]      wmask;
  } decode_t;

endpackage

// ==== verilog/rv_decoder.sv ====
// instruction decoder; turns one fetched word into the decode struct and halt requests.
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::rv_inst_u inst,
  input  logic             halted,
  output rv_pkg::decode_t  dec,
  output logic             halt_req,
  output logic             illegal_req
);
  import rv_pkg::*;

  logic            opc_imm, opc_op, opc_auipc, opc_jal;
  logic            opc_jalr, opc_load, opc_store, opc_system;
  logic [2:0]      f3;
  logic            f7_zero, f7_alt, f12_ebreak, shamt_hi_zero;
  logic            addi, slti, sltiu, andi, ori, xori, slli;
  logic            add, sub, auipc, jal, jalr, ld, sd, ebreak, nop;
  logic            fmt_i, fmt_s, fmt_u, fmt_j;
  logic            known;
  logic [xlen-1:0] imm_i, imm_s, imm_u, imm_j;

  // opcode groups.
  assign opc_imm    = (inst.r.opcode == op_imm);
  assign opc_op     = (inst.r.opcode == op_op);
  assign opc_auipc  = (inst.u.opcode == op_auipc);
  assign opc_jal    = (inst.j.opcode == op_jal);
  assign opc_jalr   = (inst.i.opcode == op_jalr);
  assign opc_load   = (inst.i.opcode == op_load);
  assign opc_store  = (inst.s.opcode == op_store);
  assign opc_system = (inst.i.opcode == op_system);

  assign f3            = inst.i.funct3;
  assign f7_zero       = (inst.r.funct7 == 7'b0000000);
  assign f7_alt        = (inst.r.funct7 == 7'b0100000); // sub.
  assign f12_ebreak    = (inst.i.imm_11_0 == 12'h001);
  assign shamt_hi_zero = (inst.i.imm_11_0[11:6] == 6'b000000); // rv64 slli.

  // recognized instructions.
  assign addi   = opc_imm & (f3 == 3'b000);
  assign slti   = opc_imm & (f3 == 3'b010);
  assign sltiu  = opc_imm & (f3 == 3'b011);
  assign andi   = opc_imm & (f3 == 3'b111);
  assign ori    = opc_imm & (f3 == 3'b110);
  assign xori   = opc_imm & (f3 == 3'b100);
  assign slli   = opc_imm & (f3 == 3'b001) & shamt_hi_zero;
  assign add    = opc_op & (f3 == 3'b000) & f7_zero;
  assign sub    = opc_op & (f3 == 3'b000) & f7_alt;
  assign auipc  = opc_auipc;
  assign jal    = opc_jal;
  assign jalr   = opc_jalr & (f3 == 3'b000);
  assign ld     = opc_load & (f3 == 3'b011);  // doubleword only.
  assign sd     = opc_store & (inst.s.funct3 == 3'b011);
  assign ebreak = opc_system & (f3 == 3'b000) & f12_ebreak;
  assign nop    = (inst == 32'h0000_0000); // all-zero word.

  assign known = addi | slti | sltiu | andi | ori | xori | slli |
                 add | sub | auipc | jal | jalr | ld | sd | ebreak;

  // immediate format select.
  assign fmt_i = addi | slti | sltiu | andi | ori | xori | slli | ld | jalr;
  assign fmt_s = sd;
  assign fmt_u = auipc;
  assign fmt_j = jal;

  assign imm_i = {{52{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
  assign imm_s = {{52{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
  assign imm_u = {{32{inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'h000};
  assign imm_j = {{43{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0}; // bit 0 implied.

  always_comb begin
    dec.rd  = inst.r.rd;
    dec.rs1 = inst.r.rs1;
    dec.rs2 = inst.r.rs2;
    dec.imm = ({xlen{fmt_i}} & imm_i) |
              ({xlen{fmt_s}} & imm_s) |
              ({xlen{fmt_u}} & imm_u) |
              ({xlen{fmt_j}} & imm_j); // zero for r-type.

    dec.need_imm = fmt_i | fmt_s | fmt_u; // no rs2 for these.

    dec.alu_op.add  = addi | add | auipc | jalr | ld | sd; // also address calc.
    dec.alu_op.sub  = sub;
    dec.alu_op.lt   = slti;
    dec.alu_op.ltu  = sltiu;
    dec.alu_op.and_ = andi;
    dec.alu_op.or_  = ori;
    dec.alu_op.xor_ = xori;
    dec.alu_op.sll  = slli;

    dec.is_auipc  = auipc;
    dec.is_jal    = jal;
    dec.is_jalr   = jalr;
    dec.is_load   = ld;
    dec.is_ebreak = ebreak;

    // no side effects once halted.
    dec.reg_wen = (addi | slti | sltiu | andi | ori | xori | slli |
                   add | sub | auipc | jal | jalr | ld) & ~halted;
    dec.mem_wen = sd & ~halted;
    dec.wmask   = sd ? 8'hff : 8'h00; // full doubleword.
  end

  assign illegal_req = ~(known | nop);
  assign halt_req    = dec.is_ebreak | illegal_req; // either one stops the core.

endmodule

// ==== verilog/rv_regfile.sv ====
// integer register file, 32 x 64 bits; two async reads and one write per clock.
`timescale 1ns/1ps

module rv_regfile (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::decode_t         dec,
  input  logic [rv_pkg::xlen-1:0] wb_data,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0; // all registers start at zero.
      end
    end else if (dec.reg_wen && (dec.rd != 5'd0)) begin
      regs[dec.rd] <= wb_data; // writes to x0 dropped.
    end
  end

  // combinational reads, x0 reads zero.
  assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

// ==== verilog/rv_execute.sv ====
// execute stage; operand muxing, alu, data-port drive and write-back select.
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::decode_t         dec,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] link,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] wb_data,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic                    mem_wen,
  output logic [7:0]              wmask
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a, op_b;
  logic [xlen-1:0] sum, diff, alu_res;
  logic            lt_bit, ltu_bit;

  assign op_a = dec.is_auipc ? pc : rs1_data;   // auipc adds to pc.
  assign op_b = dec.need_imm ? dec.imm : rs2_data;

  assign sum     = op_a + op_b;
  assign diff    = op_a - op_b;
  assign lt_bit  = ($signed(op_a) < $signed(op_b));
  assign ltu_bit = (op_a < op_b);

  // one-hot and-or select.
  assign alu_res = ({xlen{dec.alu_op.add}}  & sum) |
                   ({xlen{dec.alu_op.sub}}  & diff) |
                   ({xlen{dec.alu_op.lt}}   & {{(xlen-1){1'b0}}, lt_bit}) |
                   ({xlen{dec.alu_op.ltu}}  & {{(xlen-1){1'b0}}, ltu_bit}) |
                   ({xlen{dec.alu_op.and_}} & (op_a & op_b)) |
                   ({xlen{dec.alu_op.or_}}  & (op_a | op_b)) |
                   ({xlen{dec.alu_op.xor_}} & (op_a ^ op_b)) |
                   ({xlen{dec.alu_op.sll}}  & (op_a << op_b[5:0])); // 6-bit shamt.

  // data port, address is always rs1 + imm for ld/sd.
  assign mem_addr  = sum;
  assign mem_wdata = rs2_data;
  assign mem_wen   = dec.mem_wen;
  assign wmask     = dec.wmask;

  always_comb begin
    if (dec.is_jal || dec.is_jalr) begin
      wb_data = link; // return address.
    end else if (dec.is_load) begin
      wb_data = mem_rdata;
    end else begin
      wb_data = alu_res;
    end
  end

endmodule

// ==== verilog/rv_pc_unit.sv ====
// program counter with jump targets, link address and sticky halt/illegal state.
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::decode_t         dec,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic                    halt_req,
  input  logic                    illegal_req,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] link,
  output logic                    halted,
  output logic                    illegal
);
  import rv_pkg::*;

  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] jalr_sum;

  assign link     = pc + 64'd4; // sequential pc and jal/jalr link.
  assign jalr_sum = rs1_data + dec.imm;

  always_comb begin
    if (halted || halt_req) begin
      next_pc = pc; // freeze on halt.
    end else if (dec.is_jal) begin
      next_pc = pc + dec.imm;
    end else if (dec.is_jalr) begin
      next_pc = {jalr_sum[xlen-1:1], 1'b0}; // lsb cleared.
    end else begin
      next_pc = link;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= reset_pc;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      pc      <= next_pc;
      halted  <= halted | halt_req;                   // sticky.
      illegal <= illegal | (illegal_req & ~halted);   // only on halt entry.
    end
  end

endmodule

// ==== verilog/rv_core.sv ====
// single-cycle rv64i subset core top; connect instruction and data ports here.
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    reset,
  output logic [rv_pkg::xlen-1:0] pc,
  input  logic [31:0]             inst,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic                    mem_wen,
  output logic [7:0]              wmask,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    halted,
  output logic                    illegal
);
  import rv_pkg::*;

  rv_inst_u        inst_word;  // fetched word, format views.
  decode_t         dec;
  logic            halt_req, illegal_req;
  logic [xlen-1:0] rs1_data, rs2_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] link;

  assign inst_word = inst;

  rv_decoder i_rv_decoder (
    .inst        (inst_word),
    .halted      (halted),
    .dec         (dec),
    .halt_req    (halt_req),
    .illegal_req (illegal_req)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .reset    (reset),
    .dec      (dec),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_rv_execute (
    .dec       (dec),
    .pc        (pc),
    .link      (link),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .wb_data   (wb_data),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wen   (mem_wen),
    .wmask     (wmask)
  );

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) i_rv_pc_unit (
    .clk         (clk),
    .reset       (reset),
    .dec         (dec),
    .rs1_data    (rs1_data),
    .halt_req    (halt_req),
    .illegal_req (illegal_req),
    .pc          (pc),
    .link        (link),
    .halted      (halted),
    .illegal     (illegal)
  );

endmodule

// ==== sim/tb_clock.sv ====
// clock source for the core testbench; free-running 40 ns clock that starts low.
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam int half_period = 20; // 40 ns period.

  initial begin
    clk = 1'b0;
  end

  always begin
    #(half_period);
    clk = ~clk;
  end

endmodule

// ==== sim/tb_rv_core.sv ====
// testbench for rv_core; runs each program of the tests file and checks stores and end state.
`timescale 1ns/1ps

module tb_rv_core;

  typedef struct packed {
    int          test;
    logic [31:0] word;
  } prog_line_t; // one program word.

  typedef struct packed {
    int          test;
    logic [63:0] addr;
    logic [63:0] data;
  } mem_line_t; // data word or expected store.

  localparam int          max_cycles = 500;      // halt timeout per test.
  localparam logic [63:0] prog_limit = 64'd256;  // 64 instruction words.
  localparam logic [63:0] data_limit = 64'd512;  // 64 doublewords.
  localparam logic [63:0] reset_addr = 64'h0;    // pc after reset.

  logic        clk;
  logic        reset;
  logic [63:0] pc;
  logic [31:0] inst;
  logic [63:0] mem_addr;
  logic [63:0] mem_wdata;
  logic [63:0] mem_rdata;
  logic        mem_wen;
  logic [7:0]  wmask;
  logic        halted;
  logic        illegal;

  logic [31:0] prog_mem [64];
  logic [63:0] data_mem [64];

  string       test_name [$];
  logic        test_illegal [$]; // expected end state.
  prog_line_t  prog_q [$];
  mem_line_t   data_q [$];
  mem_line_t   store_q [$];
  mem_line_t   exp_q [$];        // stores still due in the running test.
  string       cur_name;
  int          errors;

  tb_clock i_tb_clock (.clk(clk));

  rv_core #(
    .reset_pc (reset_addr)
  ) i_rv_core (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wen   (mem_wen),
    .wmask     (wmask),
    .mem_rdata (mem_rdata),
    .halted    (halted),
    .illegal   (illegal)
  );

  // instruction memory reads as nop outside the program window.
  always_comb begin
    inst = 32'h0;
    if (pc < prog_limit)
      inst = prog_mem[pc[7:2]];
  end

  // outside the data window the whole address comes back inverted.
  always_comb begin
    mem_rdata = ~mem_addr;
    if (mem_addr < data_limit)
      mem_rdata = data_mem[mem_addr[8:3]];
  end

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED test=%s %s: expected %h, actual %h", cur_name, what, expected,
               actual);
      errors++;
    end
  endtask

  task automatic read_tests();
    int          fd;
    int          k;
    byte         tag;
    string       line;
    string       rest;
    string       name;
    logic [63:0] a;
    logic [63:0] b;
    prog_line_t  p;
    mem_line_t   m;
    fd = $fopen("sim/core_tests.dat", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the tests file sim/core_tests.dat");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 3 || line[0] == "#")
        continue; // blank or comment.
      tag = line[0];
      rest = line.substr(2, line.len() - 1);
      a = '0;
      b = '0;
      void'($sscanf(rest, "%h %h", a, b));
      m.test = test_name.size() - 1;
      m.addr = a;
      m.data = b;
      case (tag)
        "T": begin
          name = "";
          for (k = 2; k < line.len() && line[k] > 8'h20; k++) begin
            name = {name, line.substr(k, k)};
          end
          test_name.push_back(name);
          test_illegal.push_back(1'b0);
        end
        "I": begin
          p.test = test_name.size() - 1;
          p.word = a[31:0];
          prog_q.push_back(p);
        end
        "D": data_q.push_back(m);
        "S": store_q.push_back(m); // order matters.
        "E": test_illegal[test_name.size() - 1] = (line[2] == "i");
        default: begin
          $display("ERROR: unknown line in the tests file: %s", line);
          errors++;
        end
      endcase
    end
    $fclose(fd);
  endtask

  task automatic load_memories(int t);
    int n;
    n = 0;
    foreach (prog_mem[k]) begin
      prog_mem[k] = 32'h0;
    end
    foreach (data_mem[k]) begin
      data_mem[k] = {$urandom(), $urandom()}; // fresh noise per test.
    end
    foreach (prog_q[k]) begin
      if (prog_q[k].test == t && n < 64) begin
        prog_mem[n[5:0]] = prog_q[k].word;
        n++;
      end
    end
    foreach (data_q[k]) begin
      if (data_q[k].test == t && data_q[k].addr < data_limit)
        data_mem[data_q[k].addr[8:3]] = data_q[k].data;
    end
    exp_q.delete();
    foreach (store_q[k]) begin
      if (store_q[k].test == t)
        exp_q.push_back(store_q[k]);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (3) @(posedge clk); // 3 cycles in reset.
    #2;
    reset = 1'b0;
  endtask

  // compare one store with the next expected one, then update the data memory.
  task automatic take_store();
    mem_line_t e;
    if (exp_q.size() == 0) begin
      $display("ERROR: test %s: unexpected store of %h to address %h", cur_name, mem_wdata,
               mem_addr);
      errors++;
    end else begin
      e = exp_q.pop_front();
      check_value("store address", e.addr, mem_addr);
      check_value("store data", e.data, mem_wdata);
      check_value("store mask", 64'hff, {56'd0, wmask});
    end
    if (mem_addr < data_limit)
      data_mem[mem_addr[8:3]] = mem_wdata; // sd never reads mem_rdata.
  endtask

  task automatic run_test(int t);
    int          cycles;
    logic        waiting;
    logic [63:0] held_pc;
    cur_name = test_name[t];
    load_memories(t);
    apply_reset();
    check_value("pc after reset", reset_addr, pc);
    check_value("halted after reset", 64'd0, {63'd0, halted});
    check_value("illegal after reset", 64'd0, {63'd0, illegal});
    cycles = 0;
    waiting = 1'b1;
    while (waiting) begin
      @(negedge clk); // mid-cycle when the ports have settled.
      if (halted) begin
        waiting = 1'b0;
      end else if (cycles >= max_cycles) begin
        $display("ERROR: test %s: core did not halt within %0d cycles", cur_name, max_cycles);
        errors++;
        waiting = 1'b0;
      end else begin
        if (mem_wen)
          take_store();
        cycles++;
      end
    end
    if (halted) begin
      held_pc = pc;
      repeat (3) begin
        @(negedge clk);
        check_value("pc held", held_pc, pc);
        check_value("store after halt", 64'd0, {63'd0, mem_wen});
      end
      check_value("illegal", {63'd0, test_illegal[t]}, {63'd0, illegal});
      if (exp_q.size() != 0) begin
        $display("ERROR: test %s: %0d expected stores never happened", cur_name, exp_q.size());
        errors++;
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    errors = 0;
    void'($urandom(32'h5825a7e1));
    read_tests();
    if (test_name.size() == 0) begin
      $display("ERROR: no tests were found in the tests file");
      errors++;
    end
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("tests run %0d, errors %0d", test_name.size(), errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/core_tests.dat ====
# columns: T name | I instruction word | D addr data | S addr data (expected store, in order)
# E halt or E illegal ends a test; numbers are hex, addresses are byte addresses
T imm_arith
I fff00093
I ffb00093 # addi x1, x0, -5
I 0030a113 # slti x2, x1, 3
I 0030b193 # sltiu x3, x1, 3
I 0f00f213 # andi x4, x1, 0xf0
I 0040e293 # ori x5, x1, 4
I 7ff0c313 # xori x6, x1, 0x7ff
I 02409393 # slli x7, x1, 36
I 00203023 # sd x2, 0(x0)
I 00303423 # sd x3, 8(x0)
I 00403823 # sd x4, 16(x0)
I 00503c23 # sd x5, 24(x0)
I 02603023 # sd x6, 32(x0)
I 02703423 # sd x7, 40(x0)
I 00100073 # ebreak
S 0 1
S 8 0
S 10 f0
S 18 ffffffffffffffff
S 20 fffffffffffff804
S 28 ffffffb000000000
E halt
T add_sub
I fff00093 # addi x1, x0, -1
I 00200113 # addi x2, x0, 2
I 002081b3 # add x3, x1, x2
I 40200233 # sub x4, x0, x2
I 00208033 # add x0, x1, x2
I 00303023 # sd x3, 0(x0)
I 00403423 # sd x4, 8(x0)
I 00003823 # sd x0, 16(x0)
I 00100073 # ebreak
S 0 1
S 8 fffffffffffffffe
S 10 0
E halt
T ld_sd_hold
D 40 0123456789abcdef
I 04003083 # ld x1, 64(x0)
I 01108093 # addi x1, x1, 17
I 04103423 # sd x1, 72(x0)
I 00100073 # ebreak
I 00103823 # sd x1, 16(x0) after the halt
S 48 0123456789abce00
E halt
T control_flow
I 02000193 # addi x3, x0, 32
I 12345097 # auipc x1, 0x12345
I 00103023 # sd x1, 0(x0)
I 0080016f # jal x2, +8
I 00103423 # sd x1, 8(x0) skipped
I 00203423 # sd x2, 8(x0)
I 00118267 # jalr x4, 1(x3)
I 00303823 # sd x3, 16(x0) skipped
I 00403823 # sd x4, 16(x0)
I 00100073 # ebreak
S 0 12345004
S 8 10
S 10 1c
E halt
T illegal_word
I 00900093 # addi x1, x0, 9
I 00000000 # nop
I 00103023 # sd x1, 0(x0)
I 00000463 # beq x0, x0, +8
I 00103423 # sd x1, 8(x0) after the halt
S 0 9
E illegal

// ==== all.f ====
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim_run.log

verilator --binary --timing -f all.f --top-module tb_rv_core --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -qx "All tests passed" "$log"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $log"
exit 1
